/* erx_consts.svh */
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

`define PW          104      // Link packet width
`define AW          32       // Address width
`define DW          32       // Data width
`define CHIP_ID     12'h810  // Matched against dstaddr[31:20]
`define RR_REGION   4'hE     // Read response window, dstaddr[19:16]
`define CFG_REGION  4'hF     // Register window, dstaddr[19:16]
`define MBOX_ADDR   16'h0100 // Mailbox word inside the register window
`define MBOX_DEPTH  8        // Mailbox entries
`define SKID_DEPTH  4        // Per-channel skid FIFO entries
`define CFG_SEL_HI  4        // Register select field in a config address
`define CFG_SEL_LO  2

`endif

/* emesh_pkg.sv */
`include "erx_consts.svh"

package emesh_pkg;

   typedef enum logic [1:0] {
      PKT_WR = 2'd0,     // Write
      PKT_RD = 2'd1,     // Read request
      PKT_RR = 2'd2      // Read response into local window
   } pkt_class_e;

   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   typedef struct packed {
      logic [`DW-1:0] data_hi;  // Upper data of a double write
      logic [`DW-1:0] data_lo;
      logic [`AW-1:0] dstaddr;
      logic [4:0]     ctrlmode;
      datamode_e      datamode;
      logic           write;
   } emesh_wr_t;

   typedef struct packed {
      logic [`AW-1:0] srcaddr;  // Where the response goes
      logic [`DW-1:0] data_lo;
      logic [`AW-1:0] dstaddr;
      logic [4:0]     ctrlmode;
      datamode_e      datamode;
      logic           write;
   } emesh_rd_t;

   // Same 104 bits, top word read as data or return address
   typedef union packed {
      emesh_wr_t wr;
      emesh_rd_t rd;
   } emesh_packet_u;

endpackage

/* ecfg_pkg.sv */
package ecfg_pkg;

   // Value equals address bits 4..2 of the register
   typedef enum logic [2:0] {
      REG_REMAP_MODE    = 3'd0,
      REG_REMAP_SEL     = 3'd1,
      REG_REMAP_PATTERN = 3'd2,
      REG_MBOX_LO       = 3'd3,  // Head entry, low word
      REG_MBOX_HI       = 3'd4,  // Head entry, high word, pops
      REG_MBOX_COUNT    = 3'd5
   } cfg_reg_e;

   typedef enum logic [1:0] {
      REMAP_NONE   = 2'd0,
      REMAP_STATIC = 2'd1       // Bitwise select on upper 12 address bits
   } remap_mode_e;

endpackage

/* mi_if.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

interface mi_if import ecfg_pkg::*; ();
   logic           cfg_en;     // Remap register block select
   logic           mbox_en;    // Mailbox select
   logic           we;
   cfg_reg_e       addr;
   logic [`DW-1:0] din;
   logic [`DW-1:0] cfg_dout;   // Valid the cycle after cfg_en
   logic [`DW-1:0] mbox_dout;  // Valid the cycle after mbox_en

   modport master (output cfg_en, mbox_en, we, addr, din,
                   input  cfg_dout, mbox_dout);

   modport slave  (input  cfg_en, mbox_en, we, addr, din,
                   output cfg_dout, mbox_dout);
endinterface

/* erx_protocol.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module erx_protocol import emesh_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          rx_access,
   input  emesh_packet_u rx_packet,
   output logic          erx_access,
   output emesh_packet_u erx_packet,
   output pkt_class_e    erx_class
);

   logic       is_rr;     // Aimed at local read response window
   pkt_class_e rx_class;

   assign is_rr = (rx_packet.wr.dstaddr[31:20] == `CHIP_ID) &&
                  (rx_packet.wr.dstaddr[19:16] == `RR_REGION);
   assign rx_class = is_rr ? PKT_RR : (rx_packet.wr.write ? PKT_WR : PKT_RD);

   always_ff @(posedge clk) begin
      if (rst) begin
         erx_access <= 1'b0;
      end else begin
         erx_access <= rx_access;
      end
   end

   always_ff @(posedge clk) begin
      erx_packet <= rx_packet;  // Payload, no reset
      erx_class  <= rx_class;
   end

endmodule

/* erx_remap.sv */
`timescale 1ns/10ps

module erx_remap import emesh_pkg::*, ecfg_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          in_access,
   input  emesh_packet_u in_packet,
   input  pkt_class_e    in_class,
   input  remap_mode_e   remap_mode,
   input  logic [11:0]   remap_sel,
   input  logic [11:0]   remap_pattern,
   output logic          out_access,
   output emesh_packet_u out_packet,
   output pkt_class_e    out_class
);

   emesh_packet_u remapped;
   logic          do_remap;

   // Responses keep their address, only requests move
   assign do_remap = (remap_mode == REMAP_STATIC) && (in_class != PKT_RR);

   always_comb begin
      remapped = in_packet;
      if (do_remap) begin
         remapped.wr.dstaddr[31:20] = (remap_sel & remap_pattern) |
                                      (~remap_sel & in_packet.wr.dstaddr[31:20]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_access <= 1'b0;
      end else begin
         out_access <= in_access;
      end
   end

   always_ff @(posedge clk) begin
      out_packet <= remapped;  // Payload, no reset
      out_class  <= in_class;
   end

endmodule

/* erx_mailbox.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module erx_mailbox import emesh_pkg::*, ecfg_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          emesh_access,
   input  emesh_packet_u emesh_packet,
   input  pkt_class_e    emesh_class,
   mi_if.slave           mi,
   output logic          mbox_claim,
   output logic          mailbox_full,
   output logic          mailbox_not_empty
);

   localparam int MAW = $clog2(`MBOX_DEPTH);

   logic [2*`DW-1:0] mem [`MBOX_DEPTH];  // {data_hi, data_lo}
   logic [MAW-1:0]   wr_ptr;
   logic [MAW-1:0]   rd_ptr;
   logic [MAW:0]     count;
   logic             push;
   logic             pop;
   logic             rd_en;

   assign mbox_claim = emesh_access && (emesh_class == PKT_WR) &&
                       (emesh_packet.wr.dstaddr == {`CHIP_ID, `CFG_REGION, `MBOX_ADDR});
   assign push  = mbox_claim && !mailbox_full;  // Full mailbox drops the write
   assign rd_en = mi.mbox_en && !mi.we;          // Mailbox is read only on the bus
   assign pop   = rd_en && (mi.addr == REG_MBOX_HI);

   assign mailbox_full      = (count == (MAW+1)'(`MBOX_DEPTH));
   assign mailbox_not_empty = (count != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{MAW{1'b0}}, push} - {{MAW{1'b0}}, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {emesh_packet.wr.data_hi, emesh_packet.wr.data_lo};
      end
   end

   // Readback one cycle after select
   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (mi.addr)
            REG_MBOX_LO:    mi.mbox_dout <= mem[rd_ptr][`DW-1:0];
            REG_MBOX_HI:    mi.mbox_dout <= mem[rd_ptr][2*`DW-1:`DW];
            REG_MBOX_COUNT: mi.mbox_dout <= {{(`DW-MAW-1){1'b0}}, count};
            default:        mi.mbox_dout <= '0;
         endcase
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
      pop |-> mailbox_not_empty)
      else $error("erx_mailbox: pop while empty");

endmodule

/* erx_cfg.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module erx_cfg import ecfg_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   mi_if.slave         mi,
   output remap_mode_e remap_mode,
   output logic [11:0] remap_sel,
   output logic [11:0] remap_pattern
);

   logic wr_en;
   logic rd_en;

   assign wr_en = mi.cfg_en && mi.we;
   assign rd_en = mi.cfg_en && !mi.we;

   always_ff @(posedge clk) begin
      if (rst) begin
         remap_mode    <= REMAP_NONE;  // Pass-through after reset
         remap_sel     <= '0;
         remap_pattern <= '0;
      end else if (wr_en) begin
         case (mi.addr)
            REG_REMAP_MODE:    remap_mode    <= remap_mode_e'(mi.din[1:0]);
            REG_REMAP_SEL:     remap_sel     <= mi.din[11:0];
            REG_REMAP_PATTERN: remap_pattern <= mi.din[11:0];
            default: ;                      // Other selects ignored
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         case (mi.addr)
            REG_REMAP_MODE:    mi.cfg_dout <= {{(`DW-2){1'b0}}, remap_mode};
            REG_REMAP_SEL:     mi.cfg_dout <= {{(`DW-12){1'b0}}, remap_sel};
            REG_REMAP_PATTERN: mi.cfg_dout <= {{(`DW-12){1'b0}}, remap_pattern};
            default:           mi.cfg_dout <= '0;
         endcase
      end
   end

endmodule

/* ecfg_if.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module ecfg_if import emesh_pkg::*, ecfg_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          access_in,
   input  emesh_packet_u packet_in,
   input  logic          resp_wait,
   mi_if.master          mi,
   output logic          wait_out,
   output logic          resp_access,
   output emesh_packet_u resp_packet
);

   cfg_reg_e       sel;
   logic           is_mbox;
   logic           accept;
   logic           rd_pend;   // Bus read in flight, dout lands next
   logic           rd_mbox;   // Which dout to pick up
   logic [`AW-1:0] ret_addr;

   assign sel     = cfg_reg_e'(packet_in.wr.dstaddr[`CFG_SEL_HI:`CFG_SEL_LO]);
   assign is_mbox = sel inside {REG_MBOX_LO, REG_MBOX_HI, REG_MBOX_COUNT};
   assign accept  = access_in && !wait_out;

   // One-cycle bus access in the accepting cycle
   assign mi.cfg_en  = accept && !is_mbox;
   assign mi.mbox_en = accept && is_mbox;
   assign mi.we      = packet_in.wr.write;
   assign mi.addr    = sel;
   assign mi.din     = packet_in.wr.data_lo;

   assign wait_out = rd_pend || resp_access;  // Held until response leaves

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_pend     <= 1'b0;
         resp_access <= 1'b0;
      end else begin
         rd_pend <= accept && !packet_in.wr.write;
         if (rd_pend) begin
            resp_access <= 1'b1;
         end else if (!resp_wait) begin
            resp_access <= 1'b0;   // Taken by the arbiter
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !packet_in.wr.write) begin
         ret_addr <= packet_in.rd.srcaddr;
         rd_mbox  <= is_mbox;
      end
      if (rd_pend) begin
         resp_packet.wr <= '{data_hi:  '0,
                             data_lo:  rd_mbox ? mi.mbox_dout : mi.cfg_dout,
                             dstaddr:  ret_addr,
                             ctrlmode: '0,
                             datamode: DM_WORD,
                             write:    1'b1};
      end
   end

   a_no_req_in_wait: assert property (@(posedge clk) disable iff (rst)
      access_in |-> !wait_out)
      else $error("ecfg_if: request while wait_out high");

endmodule

/* erx_arbiter.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module erx_arbiter import emesh_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          erx_access,
   input  emesh_packet_u erx_packet,
   input  pkt_class_e    erx_class,
   input  logic          mbox_claim,
   input  logic          cfg_access,
   input  emesh_packet_u cfg_packet,
   input  logic          rxwr_wait,
   input  logic          rxrd_wait,
   input  logic          rxrr_wait,
   output logic          rx_wr_wait,
   output logic          rx_rd_wait,
   output logic          cfg_wait,
   output logic          rxwr_access,
   output emesh_packet_u rxwr_packet,
   output logic          rxrd_access,
   output emesh_packet_u rxrd_packet,
   output logic          rxrr_access,
   output emesh_packet_u rxrr_packet
);

   localparam int SAW = $clog2(`SKID_DEPTH);

   logic [2:0]    push;   // Indexed by class, WR RD RR
   logic [2:0]    pop;
   logic [2:0]    empty;
   logic [2:0]    full;
   emesh_packet_u head [3];

   for (genvar c = 0; c < 3; c++) begin : g_skid
      emesh_packet_u  mem [`SKID_DEPTH];
      logic [SAW-1:0] wr_ptr;
      logic [SAW-1:0] rd_ptr;
      logic [SAW:0]   count;

      assign push[c]  = erx_access && !mbox_claim && (erx_class == pkt_class_e'(c));
      assign empty[c] = (count == '0);
      assign full[c]  = (count == (SAW+1)'(`SKID_DEPTH));
      assign head[c]  = mem[rd_ptr];

      always_ff @(posedge clk) begin
         if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (push[c]) wr_ptr <= wr_ptr + 1'b1;
            if (pop[c]) rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{SAW{1'b0}}, push[c]} - {{SAW{1'b0}}, pop[c]};
         end
      end

      always_ff @(posedge clk) begin
         if (push[c]) mem[wr_ptr] <= erx_packet;
      end

      a_no_push_full: assert property (@(posedge clk) disable iff (rst)
         push[c] |-> !full[c])
         else $error("erx_arbiter: skid FIFO %0d overrun", c);
   end

   // Link side stalls as soon as anything is queued
   assign rx_wr_wait = !empty[0] || rxwr_wait;
   assign rx_rd_wait = !empty[1] || !empty[2] || rxrd_wait || rxrr_wait;

   assign rxwr_access = !empty[0] && !rxwr_wait;
   assign rxwr_packet = head[0];
   assign rxrd_access = !empty[1] && !rxrd_wait;
   assign rxrd_packet = head[1];

   // Read response channel, link FIFO first, config readback second
   assign rxrr_access = (!empty[2] || cfg_access) && !rxrr_wait;
   assign rxrr_packet = !empty[2] ? head[2] : cfg_packet;
   assign cfg_wait    = !empty[2] || rxrr_wait;

   assign pop[0] = rxwr_access;
   assign pop[1] = rxrd_access;
   assign pop[2] = !empty[2] && !rxrr_wait;

endmodule

/* erx_core.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module erx_core import emesh_pkg::*, ecfg_pkg::*; (
   input  logic           clk,
   input  logic           rst,
   input  logic           rx_access,
   input  logic [`PW-1:0] rx_packet,
   input  logic           rxwr_wait,
   input  logic           rxrd_wait,
   input  logic           rxrr_wait,
   input  logic           erx_cfg_access,
   input  logic [`PW-1:0] erx_cfg_packet,
   output logic           rx_wr_wait,
   output logic           rx_rd_wait,
   output logic           rxwr_access,
   output logic [`PW-1:0] rxwr_packet,
   output logic           rxrd_access,
   output logic [`PW-1:0] rxrd_packet,
   output logic           rxrr_access,
   output logic [`PW-1:0] rxrr_packet,
   output logic           erx_cfg_wait,
   output logic           mailbox_full,
   output logic           mailbox_not_empty
);

   logic          erx_access;      // Protocol stage out
   emesh_packet_u erx_packet;
   pkt_class_e    erx_class;
   logic          remap_access;    // Remap stage out
   emesh_packet_u remap_packet;
   pkt_class_e    remap_class;
   remap_mode_e   remap_mode;
   logic [11:0]   remap_sel;
   logic [11:0]   remap_pattern;
   logic          mbox_claim;
   logic          cfg_resp_access; // Config readback to arbiter
   emesh_packet_u cfg_resp_packet;
   logic          cfg_resp_wait;

   mi_if mi ();

   erx_protocol u_protocol (
      .clk, .rst, .rx_access, .rx_packet,
      .erx_access, .erx_packet, .erx_class);

   erx_remap u_remap (
      .clk, .rst,
      .in_access  (erx_access),
      .in_packet  (erx_packet),
      .in_class   (erx_class),
      .remap_mode, .remap_sel, .remap_pattern,
      .out_access (remap_access),
      .out_packet (remap_packet),
      .out_class  (remap_class));

   erx_mailbox u_mailbox (
      .clk, .rst,
      .emesh_access (remap_access),
      .emesh_packet (remap_packet),
      .emesh_class  (remap_class),
      .mi           (mi.slave),
      .mbox_claim, .mailbox_full, .mailbox_not_empty);

   erx_cfg u_cfg (
      .clk, .rst,
      .mi (mi.slave),
      .remap_mode, .remap_sel, .remap_pattern);

   ecfg_if u_cfgif (
      .clk, .rst,
      .access_in   (erx_cfg_access),
      .packet_in   (erx_cfg_packet),
      .resp_wait   (cfg_resp_wait),
      .mi          (mi.master),
      .wait_out    (erx_cfg_wait),
      .resp_access (cfg_resp_access),
      .resp_packet (cfg_resp_packet));

   erx_arbiter u_arbiter (
      .clk, .rst,
      .erx_access (remap_access),
      .erx_packet (remap_packet),
      .erx_class  (remap_class),
      .mbox_claim,
      .cfg_access (cfg_resp_access),
      .cfg_packet (cfg_resp_packet),
      .rxwr_wait, .rxrd_wait, .rxrr_wait,
      .rx_wr_wait, .rx_rd_wait,
      .cfg_wait   (cfg_resp_wait),
      .rxwr_access, .rxwr_packet,
      .rxrd_access, .rxrd_packet,
      .rxrr_access, .rxrr_packet);

endmodule

/* tb_erx_core.sv */
`timescale 1ns/10ps
`include "erx_consts.svh"

module tb_erx_core import ecfg_pkg::*; ();

   localparam int          TIMEOUT        = 2000;  // Cycles allowed per wait loop
   localparam logic [31:0] MBOX_FULL_ADDR = {`CHIP_ID, `CFG_REGION, `MBOX_ADDR};

   logic           clk = 1'b0;
   logic           rst;
   logic           rx_access;
   logic [`PW-1:0] rx_packet;
   logic           rxwr_wait = 1'b0;      // Owned by the wait randomizer
   logic           rxrd_wait = 1'b0;
   logic           rxrr_wait = 1'b0;
   logic           erx_cfg_access;
   logic [`PW-1:0] erx_cfg_packet;
   logic           rx_wr_wait;
   logic           rx_rd_wait;
   logic           rxwr_access;
   logic [`PW-1:0] rxwr_packet;
   logic           rxrd_access;
   logic [`PW-1:0] rxrd_packet;
   logic           rxrr_access;
   logic [`PW-1:0] rxrr_packet;
   logic           erx_cfg_wait;
   logic           mailbox_full;
   logic           mailbox_not_empty;

   integer         seed      = 32'h23162e7e;  // Link stimulus stream
   integer         wait_seed = 32'h23162e7e;  // Back-pressure stream
   logic           rand_waits = 1'b0;
   logic [1:0]     mode_m  = 2'd0;            // Remap register model
   logic [11:0]    sel_m   = '0;
   logic [11:0]    pat_m   = '0;
   logic [11:0]    ret_seq = '0;              // Return address tag for config reads
   int             mb_count = 0;              // Mailbox entries sent and not yet popped
   logic [31:0]    mb_hi [`MBOX_DEPTH];
   logic [31:0]    mb_lo [`MBOX_DEPTH];
   logic [`PW-1:0] wr_q [$];                  // Expected packets per channel
   logic [`PW-1:0] rd_q [$];
   logic [`PW-1:0] rr_q [$];
   logic [63:0]    resp_q [$];                // {data, return address}

   erx_core uut (.*);

   always #20 clk = ~clk;

   always @(negedge clk) begin
      logic [31:0] w;
      w = $random(wait_seed);
      rxwr_wait <= rand_waits && (w[1:0] == 2'd0);  // Roughly one cycle in four
      rxrd_wait <= rand_waits && (w[3:2] == 2'd0);
      rxrr_wait <= rand_waits && (w[5:4] == 2'd0);
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Regression failed");
      $fatal(1, "simulation stopped");
   endtask

   function automatic logic [`PW-1:0] make_pkt(input logic [31:0] hi, input logic [31:0] lo,
                                                input logic [31:0] addr, input logic wr);
      return {hi, lo, addr, 5'd0, 2'd2, wr};  // Word mode, no ctrlmode
   endfunction

   function automatic logic [11:0] remap_addr(input logic [11:0] up);
      logic [11:0] r;
      r = up;
      if (mode_m == 2'd1) begin
         for (int i = 0; i < 12; i++) begin
            if (sel_m[i]) r[i] = pat_m[i];  // Selected bit taken from pattern
         end
      end
      return r;
   endfunction

   task automatic send_link(input logic [`PW-1:0] pkt, input logic to_wr);
      int t;
      t = 0;
      while (to_wr ? rx_wr_wait : rx_rd_wait) begin  // Hold off under back-pressure
         rx_access = 1'b0;
         @(negedge clk);
         t++;
         if (t > TIMEOUT) stop_run("Timeout waiting for link wait to fall");
      end
      rx_access = 1'b1;
      rx_packet = pkt;
      @(negedge clk);
      rx_access = 1'b0;
   endtask

   task automatic send_random(input int kind);
      logic [31:0]    hi;
      logic [31:0]    lo;
      logic [31:0]    addr;
      logic [`PW-1:0] pkt;
      logic [`PW-1:0] want;
      hi   = $random(seed);
      lo   = $random(seed);
      addr = $random(seed);
      if (kind == 2) begin
         addr[31:16] = {`CHIP_ID, `RR_REGION};  // Local response window
         pkt = make_pkt(hi, lo, addr, hi[0]);
         rr_q.push_back(pkt);
         send_link(pkt, 1'b0);
      end else begin
         addr[19] = 1'b0;                       // Keeps clear of RR and config windows
         pkt  = make_pkt(hi, lo, addr, kind == 0);
         want = pkt;
         want[39:28] = remap_addr(addr[31:20]);
         if (kind == 0) wr_q.push_back(want);
         else rd_q.push_back(want);
         send_link(pkt, kind == 0);
      end
   endtask

   task automatic send_mix();
      logic [31:0] r;
      r = $random(seed);
      send_random((r[1:0] == 2'd3) ? 0 : int'(r[1:0]));
   endtask

   task automatic cfg_op(input logic wr, input cfg_reg_e sel, input logic [31:0] data,
                         input logic [31:0] ret);
      int t;
      t = 0;
      while (erx_cfg_wait) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) stop_run("Timeout waiting for erx_cfg_wait to fall");
      end
      erx_cfg_access = 1'b1;
      erx_cfg_packet = make_pkt(ret, data, {`CHIP_ID, `CFG_REGION, 11'h0, sel, 2'b00}, wr);
      @(negedge clk);
      erx_cfg_access = 1'b0;
   endtask

   task automatic cfg_write(input cfg_reg_e sel, input logic [31:0] data);
      cfg_op(1'b1, sel, data, 32'h0);
      case (sel)
         REG_REMAP_MODE:    mode_m = data[1:0];
         REG_REMAP_SEL:     sel_m  = data[11:0];
         REG_REMAP_PATTERN: pat_m  = data[11:0];
         default: ;                          // Mailbox is read only
      endcase
   endtask

   task automatic cfg_read(input cfg_reg_e sel, input logic [31:0] value);
      logic [31:0] ret;
      ret = {12'h123, 8'h00, ret_seq};      // Never inside the local chip
      ret_seq = ret_seq + 1'b1;
      resp_q.push_back({value, ret});
      cfg_op(1'b0, sel, 32'h0, ret);
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (wr_q.size() != 0 || rd_q.size() != 0 || rr_q.size() != 0 ||
             resp_q.size() != 0 || erx_cfg_wait) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) stop_run("Timeout waiting for the output channels to drain");
      end
   endtask

   // Scoreboard, in order per channel
   always @(posedge clk) begin
      if (!rst && rxwr_access) begin
         if (wr_q.size() == 0) begin
            stop_run("Packet on the write channel when none was expected");
         end else begin
            a_wr_match: assert (rxwr_packet === wr_q[0])
               else stop_run($sformatf("ERROR at %0d ns: rxwr got %h, expected %h",
                                       $time, rxwr_packet, wr_q[0]));
            void'(wr_q.pop_front());
         end
      end
      if (!rst && rxrd_access) begin
         if (rd_q.size() == 0) begin
            stop_run("Packet on the read channel when none was expected");
         end else begin
            a_rd_match: assert (rxrd_packet === rd_q[0])
               else stop_run($sformatf("ERROR at %0d ns: rxrd got %h, expected %h",
                                       $time, rxrd_packet, rd_q[0]));
            void'(rd_q.pop_front());
         end
      end
      if (!rst && rxrr_access) begin
         if (rxrr_packet[39:24] == {`CHIP_ID, `RR_REGION}) begin  // Link response
            if (rr_q.size() == 0) begin
               stop_run("Link read response that was never sent");
            end else begin
               a_rr_match: assert (rxrr_packet === rr_q[0])
                  else stop_run($sformatf("ERROR at %0d ns: rxrr got %h, expected %h",
                                          $time, rxrr_packet, rr_q[0]));
               void'(rr_q.pop_front());
            end
         end else if (resp_q.size() == 0) begin
            stop_run("Config readback response with no request pending");
         end else begin
            a_resp_match: assert (rxrr_packet[71:8] === resp_q[0] && rxrr_packet[0])
               else stop_run($sformatf("ERROR at %0d ns: readback got %h, expected %h",
                                       $time, rxrr_packet[71:8], resp_q[0]));
            void'(resp_q.pop_front());
         end
      end
   end

   a_mbox_hidden: assert property (@(posedge clk) disable iff (rst)
      rxwr_access |-> rxwr_packet[39:8] != MBOX_FULL_ADDR)
      else stop_run($sformatf("ERROR at %0d ns: mailbox write leaked to rxwr", $time));

   a_full_model: assert property (@(posedge clk) disable iff (rst)
      mailbox_full |-> mb_count == `MBOX_DEPTH)
      else stop_run($sformatf("ERROR at %0d ns: mailbox_full with %0d entries held",
                              $time, mb_count));

   a_not_empty_model: assert property (@(posedge clk) disable iff (rst)
      mailbox_not_empty |-> mb_count != 0)
      else stop_run($sformatf("ERROR at %0d ns: mailbox_not_empty with no entry held",
                              $time));

   initial begin
      logic [31:0] r;
      int          t;
      rst            = 1'b1;
      rx_access      = 1'b0;
      rx_packet      = '0;
      erx_cfg_access = 1'b0;
      erx_cfg_packet = '0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      a_reset_idle: assert (!rxwr_access && !rxrd_access && !rxrr_access && !rx_wr_wait &&
                            !rx_rd_wait && !erx_cfg_wait && !mailbox_full &&
                            !mailbox_not_empty)
         else stop_run($sformatf("ERROR at %0d ns: outputs not idle after reset", $time));

      repeat (12) send_random(0);                      // Remap off, writes untouched
      for (int i = 0; i < 16; i++) send_random(1 + i % 2);
      wait_drain();

      r = $random(seed);                                // Static remap on requests
      cfg_write(REG_REMAP_SEL, {20'h0, r[11:0]});
      cfg_write(REG_REMAP_PATTERN, {20'h0, r[23:12]});
      cfg_write(REG_REMAP_MODE, 32'd1);
      cfg_read(REG_REMAP_MODE, {30'h0, mode_m});
      cfg_read(REG_REMAP_SEL, {20'h0, sel_m});
      cfg_read(REG_REMAP_PATTERN, {20'h0, pat_m});
      for (int i = 0; i < 24; i++) send_random(i % 3);
      wait_drain();

      cfg_write(REG_REMAP_MODE, 32'd0);                // Mailbox address must stay put
      for (int i = 0; i < `MBOX_DEPTH; i++) begin
         mb_hi[i] = $random(seed);
         mb_lo[i] = $random(seed);
         mb_count++;
         send_link(make_pkt(mb_hi[i], mb_lo[i], MBOX_FULL_ADDR, 1'b1), 1'b1);
      end
      t = 0;
      while (!mailbox_full) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) stop_run("Timeout waiting for mailbox_full");
      end
      a_mbox_occupied: assert (mailbox_not_empty)
         else stop_run($sformatf("ERROR at %0d ns: mailbox_not_empty low with %0d entries",
                                 $time, mb_count));
      cfg_read(REG_MBOX_COUNT, `MBOX_DEPTH);
      for (int i = 0; i < `MBOX_DEPTH; i++) begin
         cfg_read(REG_MBOX_LO, mb_lo[i]);              // Peek
         cfg_read(REG_MBOX_HI, mb_hi[i]);              // Pop
         mb_count--;
         cfg_read(REG_MBOX_COUNT, `MBOX_DEPTH - 1 - i);
      end
      wait_drain();

      fork                                              // Readback against link traffic
         repeat (12) send_random(2);
         repeat (6) cfg_read(REG_REMAP_PATTERN, {20'h0, pat_m});
      join
      wait_drain();

      cfg_write(REG_REMAP_MODE, 32'd1);
      rand_waits <= 1'b1;
      fork
         repeat (60) send_mix();
         repeat (10) cfg_read(REG_REMAP_SEL, {20'h0, sel_m});
      join
      wait_drain();
      rand_waits <= 1'b0;

      if (!mailbox_not_empty && !mailbox_full && wr_q.size() == 0 && rd_q.size() == 0 &&
          rr_q.size() == 0 && resp_q.size() == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         stop_run("Mailbox or expected queues not empty at end of run");
      end
   end

endmodule

/* sources.f */
+incdir+.
emesh_pkg.sv
ecfg_pkg.sv
mi_if.sv
erx_protocol.sv
erx_remap.sv
erx_mailbox.sv
erx_cfg.sv
ecfg_if.sv
erx_arbiter.sv
erx_core.sv
tb_erx_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build the erx_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_erx_core -o sim_erx
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_erx 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
   exit 0
fi
exit 1
